/* list.f */
+incdir+src
src/bt656cap_pkg.sv
src/bt656cap_decoder.sv
src/bt656cap_colorspace.sv
src/bt656cap_fifo.sv
src/bt656cap.sv
tests/bt656cap_properties.sv
tests/bt656cap_checker.sv
tests/tb_bt656cap.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the BT.656 capture testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports success.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_bt656cap -o sim_bt656cap
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_bt656cap +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* src/bt656cap.sv */
// ========================================================================
// BT.656 capture front end top level. Byte stream in, buffered RGB565
// pixel pairs out with valid/ready and a sticky overflow flag.
// ========================================================================

module bt656cap import bt656cap_pkg::*; (
	input  logic      vid_clk,
	input  logic      rst_i,
	input  sample_t   byte_i,
	input  logic      pix_ready_i,
	output logic      pix_valid_o,
	output pix_pair_t pix_o,
	output logic      overflow_o
);

	logic      ycc_valid, ycc_ready;
	ycc_word_t ycc_word;
	logic      pair_valid;
	pix_pair_t pair;

	bt656cap_decoder i_decoder (
		.vid_clk     (vid_clk),
		.rst_i       (rst_i),
		.byte_i      (byte_i),
		.ycc_ready_i (ycc_ready),
		.ycc_valid_o (ycc_valid),
		.ycc_o       (ycc_word)
	);

	bt656cap_colorspace i_colorspace (
		.vid_clk      (vid_clk),
		.rst_i        (rst_i),
		.ycc_valid_i  (ycc_valid),
		.ycc_i        (ycc_word),
		.ycc_ready_o  (ycc_ready),
		.pair_valid_o (pair_valid),
		.pair_o       (pair)
	);

	bt656cap_fifo i_fifo (
		.vid_clk    (vid_clk),
		.rst_i      (rst_i),
		.wr_valid_i (pair_valid),
		.wr_data_i  (pair),
		.rd_ready_i (pix_ready_i),
		.rd_valid_o (pix_valid_o),
		.rd_data_o  (pix_o),
		.overflow_o (overflow_o)
	);

endmodule

/* src/bt656cap_colorspace.sv */
// ========================================================================
// YCbCr 4:2:2 to RGB565 converter. One registered multiplier is shared
// over four cycles per word; a new word may be accepted every 4 cycles
// and the pixel pair appears 5 cycles after its accept.
// ========================================================================

`include "bt656cap_settings.svh"

module bt656cap_colorspace import bt656cap_pkg::*; (
	input  logic      vid_clk,
	input  logic      rst_i,
	input  logic      ycc_valid_i,
	input  ycc_word_t ycc_i,
	output logic      ycc_ready_o,
	output logic      pair_valid_o,
	output pix_pair_t pair_o
);

	csc_state_t         state_q, state_d;
	ycc_word_t          word_q;              // word in the multiply sequence
	logic               accept;
	sample_t            mult_c;
	logic [8:0]         mult_k;
	logic signed [8:0]  mult_a;              // chroma minus 128
	logic signed [17:0] mult_q;
	logic signed [9:0]  term;
	logic signed [10:0] r0_q, g0_q, b0_q, r1_q, g1_q, b1_q;
	logic signed [10:0] g0_fin, g1_fin;

	function automatic sample_t clamp8(input logic signed [10:0] v);
		if (v < 0)
			return 8'h00;
		else if (v > 11'sd255)
			return 8'hff;
		else
			return v[7:0];
	endfunction

	function automatic rgb565_t pack565(input sample_t r, input sample_t g, input sample_t b);
		return {r[7:3], g[7:2], b[7:3]};
	endfunction

	assign ycc_ready_o = (state_q == CSC_IDLE) || (state_q == CSC_GCR);
	assign accept      = ycc_valid_i && ycc_ready_o;

	// ====================================================================
	// controller and multiplier operand select
	// ====================================================================
	always_comb begin
		state_d = state_q;
		mult_c  = ycc_i.cr;
		mult_k  = `BT656CAP_K_RCR;
		case (state_q)
			CSC_IDLE: begin
				if (accept)
					state_d = CSC_RED; // R product of the new word is started
			end
			CSC_RED: begin
				mult_c  = word_q.cb;
				mult_k  = `BT656CAP_K_BCB;
				state_d = CSC_BLUE;
			end
			CSC_BLUE: begin
				mult_c  = word_q.cb;
				mult_k  = `BT656CAP_K_GCB;
				state_d = CSC_GCB;
			end
			CSC_GCB: begin
				mult_c  = word_q.cr;
				mult_k  = `BT656CAP_K_GCR;
				state_d = CSC_GCR;
			end
			CSC_GCR: state_d = accept ? CSC_RED : CSC_IDLE;
			default: state_d = CSC_IDLE;
		endcase
	end

	always_ff @(posedge vid_clk) begin
		if (rst_i)
			state_q <= CSC_IDLE;
		else
			state_q <= state_d;
	end

	// ====================================================================
	// datapath
	// ====================================================================
	assign mult_a = $signed({1'b0, mult_c}) - 9'sd128;
	assign term   = mult_q[17:8];                  // floor of product / 256
	assign g0_fin = g0_q - term;
	assign g1_fin = g1_q - term;

	always_ff @(posedge vid_clk) begin
		mult_q <= mult_a * $signed({1'b0, mult_k});
		if (accept) begin
			word_q <= ycc_i;
			r0_q <= $signed({3'b000, ycc_i.y0});
			g0_q <= $signed({3'b000, ycc_i.y0});
			b0_q <= $signed({3'b000, ycc_i.y0});
			r1_q <= $signed({3'b000, ycc_i.y1});
			g1_q <= $signed({3'b000, ycc_i.y1});
			b1_q <= $signed({3'b000, ycc_i.y1});
		end
		case (state_q)
			CSC_RED: begin
				r0_q <= r0_q + term;
				r1_q <= r1_q + term;
			end
			CSC_BLUE: begin
				b0_q <= b0_q + term;
				b1_q <= b1_q + term;
			end
			CSC_GCB: begin
				g0_q <= g0_q - term;
				g1_q <= g1_q - term;
			end
			default: ;
		endcase
	end

	// output register takes the last G term on the fly
	always_ff @(posedge vid_clk) begin
		if (state_q == CSC_GCR) begin
			pair_o <= '{px0: pack565(clamp8(r0_q), clamp8(g0_fin), clamp8(b0_q)),
				px1: pack565(clamp8(r1_q), clamp8(g1_fin), clamp8(b1_q)),
				field: word_q.field, sol: word_q.sol};
		end
	end

	always_ff @(posedge vid_clk) begin
		if (rst_i)
			pair_valid_o <= 1'b0;
		else
			pair_valid_o <= (state_q == CSC_GCR);
	end

endmodule

/* src/bt656cap_decoder.sv */
// ========================================================================
// BT.656 stream decoder. Finds FF 00 00 XY timing codes, tracks the F and
// V bits and packs each active Cb Y0 Cr Y1 group into one 4:2:2 word,
// presented for a single cycle after the Y1 byte.
// ========================================================================

module bt656cap_decoder import bt656cap_pkg::*; (
	input  logic      vid_clk,
	input  logic      rst_i,
	input  sample_t   byte_i,
	input  logic      ycc_ready_i,
	output logic      ycc_valid_o,
	output ycc_word_t ycc_o
);

	sample_t    sh1_q, sh2_q, sh3_q; // sh1 is the newest byte
	logic       code_det;
	logic       field_q;
	logic       vblank_q;
	logic       active_q;            // between SAV and EAV
	logic [1:0] phase_q;
	logic       sol_pend_q;
	logic       emit;
	sample_t    cb_q, y0_q, cr_q;

	assign code_det = (sh3_q == 8'hff) && (sh2_q == 8'h00) && (sh1_q == 8'h00);

	// the XY byte of an EAV lands on phase 3, so a code never emits
	assign emit = active_q && !vblank_q && (phase_q == 2'd3) && !code_det;

	// ====================================================================
	// timing reference tracking
	// ====================================================================
	always_ff @(posedge vid_clk) begin
		if (rst_i) begin
			sh1_q      <= '0;
			sh2_q      <= '0;
			sh3_q      <= '0;
			field_q    <= 1'b0;
			vblank_q   <= 1'b1;
			active_q   <= 1'b0;
			phase_q    <= 2'd0;
			sol_pend_q <= 1'b0;
			ycc_valid_o <= 1'b0;
		end else begin
			sh1_q <= byte_i;
			sh2_q <= sh1_q;
			sh3_q <= sh2_q;
			if (code_det) begin
				field_q  <= byte_i[6];
				vblank_q <= byte_i[5];
				active_q <= !byte_i[4]; // H=0 is SAV
				phase_q  <= 2'd0;
				sol_pend_q <= !byte_i[4];
			end else if (active_q) begin
				phase_q <= phase_q + 2'd1;
			end
			if (emit) begin
				sol_pend_q <= 1'b0;
			end
			if (emit) begin
				ycc_valid_o <= 1'b1;
			end else if (ycc_ready_i) begin
				ycc_valid_o <= 1'b0; // held only if the converter stalls
			end
		end
	end

	// ====================================================================
	// 4:2:2 word assembly
	// ====================================================================
	always_ff @(posedge vid_clk) begin
		case (phase_q)
			2'd0: cb_q <= byte_i;
			2'd1: y0_q <= byte_i;
			2'd2: cr_q <= byte_i;
			default: ;
		endcase
		if (emit) begin
			ycc_o <= '{cb: cb_q, y0: y0_q, cr: cr_q, y1: byte_i,
				field: field_q, sol: sol_pend_q};
		end
	end

endmodule

/* src/bt656cap_fifo.sv */
// ========================================================================
// Pixel pair buffer. Writes never stall: a pair that finds the buffer
// full is dropped and the sticky overflow flag is raised until reset.
// ========================================================================

`include "bt656cap_settings.svh"

module bt656cap_fifo import bt656cap_pkg::*; #(
	parameter int DEPTH = `BT656CAP_FIFO_DEPTH
) (
	input  logic      vid_clk,
	input  logic      rst_i,
	input  logic      wr_valid_i,
	input  pix_pair_t wr_data_i,
	input  logic      rd_ready_i,
	output logic      rd_valid_o,
	output pix_pair_t rd_data_o,
	output logic      overflow_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	pix_pair_t     mem [DEPTH];
	logic [AW-1:0] wr_ptr_q, rd_ptr_q;
	logic [CW-1:0] count_q;
	logic          full, do_rd, do_wr;

	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
		if (p == AW'(DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	assign full       = (count_q == CW'(DEPTH));
	assign rd_valid_o = (count_q != '0);
	assign rd_data_o  = mem[rd_ptr_q];
	assign do_rd      = rd_valid_o && rd_ready_i;
	assign do_wr      = wr_valid_i && (!full || do_rd); // full slot frees on a read

	always_ff @(posedge vid_clk) begin
		if (do_wr)
			mem[wr_ptr_q] <= wr_data_i;
	end

	always_ff @(posedge vid_clk) begin
		if (rst_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr_q <= ptr_next(wr_ptr_q);
			if (do_rd)
				rd_ptr_q <= ptr_next(rd_ptr_q);
			case ({do_wr, do_rd})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
			if (wr_valid_i && !do_wr)
				overflow_o <= 1'b1; // pair dropped
		end
	end

endmodule

/* src/bt656cap_pkg.sv */
// ========================================================================
// Types shared by the capture decoder, colour converter and pixel FIFO.
// Modules take these in with a wildcard import in their header.
// ========================================================================

package bt656cap_pkg;

	typedef logic [7:0]  sample_t; // one luma or chroma byte
	typedef logic [15:0] rgb565_t; // r[15:11] g[10:5] b[4:0]

	typedef struct packed {
		sample_t cb;
		sample_t y0;
		sample_t cr;
		sample_t y1;
		logic    field; // F bit of the current field
		logic    sol;   // first word after SAV
	} ycc_word_t;

	typedef struct packed {
		rgb565_t px0;
		rgb565_t px1;
		logic    field;
		logic    sol;
	} pix_pair_t;

	typedef enum logic [2:0] {CSC_IDLE, CSC_RED, CSC_BLUE, CSC_GCB, CSC_GCR} csc_state_t;

endpackage

/* src/bt656cap_settings.svh */
// ========================================================================
// Build-time constants for the BT.656 capture front end.
// Include this in any file that sizes the pixel FIFO or needs the
// YCbCr to RGB coefficients.
// ========================================================================

`ifndef BT656CAP_SETTINGS_SVH
`define BT656CAP_SETTINGS_SVH

`define BT656CAP_FIFO_DEPTH 8 // pixel pairs held before dropping

// colour coefficients in units of 1/256
`define BT656CAP_K_RCR 9'd359 // 1.402, Cr into R
`define BT656CAP_K_BCB 9'd454 // 1.772, Cb into B
`define BT656CAP_K_GCB 9'd88  // 0.344, Cb out of G
`define BT656CAP_K_GCR 9'd183 // 0.714, Cr out of G

`endif

/* tests/bt656cap_checker.sv */
// ========================================================================
// Scoreboard for the capture front end. The testbench queues expected
// pixel pairs, this module pops one on every output handshake and also
// times the first pair of a line when the latency check is armed.
// ========================================================================

module bt656cap_checker import bt656cap_pkg::*; (
	input logic      vid_clk,
	input logic      rst_i,
	input logic      pix_valid_i,
	input pix_pair_t pix_i,
	input logic      pix_ready_i,
	input logic      overflow_i,
	input logic      lat_arm_i,  // time the next rising edge of pix_valid
	input int        cyc_i,
	input int        y1_edge_i   // edge that drove the Y1 byte
);

	pix_pair_t exp_q[$];
	pix_pair_t want;
	int        error_count = 0;
	int        test_errors = 0;
	int        test_pairs = 0;
	int        total_pairs = 0;
	int        tests_done = 0;
	logic      valid_q = 1'b0;
	logic      lat_done = 1'b0;

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic expect_pair(input pix_pair_t p);
		exp_q.push_back(p);
	endtask

	// sampled mid-cycle, a handshake here completes on the next rising edge
	always @(negedge vid_clk) begin
		if (!rst_i && pix_valid_i && pix_ready_i) begin
			if (exp_q.size() == 0) begin
				$display("pixel pair delivered when none was expected: %h", pix_i);
				test_errors++;
			end else begin
				want = exp_q.pop_front();
				if (pix_i !== want) begin
					$display("FAIL pix_o got %h expected %h", pix_i, want);
					test_errors++;
				end
				test_pairs++;
			end
		end
		if (lat_arm_i && !lat_done && pix_valid_i && !valid_q) begin
			if (cyc_i - y1_edge_i != 7) begin
				$display("FAIL pix_valid_o latency got %0h expected %0h",
					cyc_i - y1_edge_i, 7);
				test_errors++;
			end
			lat_done = 1'b1;
		end
		if (!lat_arm_i)
			lat_done = 1'b0;
		valid_q = pix_valid_i;
	end

	task automatic end_test(input string name, input logic exp_ovf);
		if (exp_q.size() != 0) begin
			$display("%0d expected pixel pairs never came out", exp_q.size());
			test_errors++;
			exp_q.delete();
		end
		if (overflow_i !== exp_ovf) begin
			$display("FAIL overflow_o got %h expected %h", overflow_i, exp_ovf);
			test_errors++;
		end
		$display("test %s: %0d pairs checked, %0d errors", name, test_pairs, test_errors);
		error_count += test_errors;
		total_pairs += test_pairs;
		tests_done++;
		test_errors = 0;
		test_pairs  = 0;
	endtask

	task automatic report_totals(input int unsigned assert_fails);
		$display("%0d tests, %0d pairs checked, %0d check errors, %0d assertion failures",
			tests_done, total_pairs, error_count, assert_fails);
	endtask

endmodule

/* tests/bt656cap_properties.sv */
// ========================================================================
// Assertions on the colour converter, bound into every converter instance.
// They cover the input rate and the fixed five cycle pair latency.
// ========================================================================

module bt656cap_properties (
	input logic vid_clk,
	input logic rst_i,
	input logic ycc_valid_i,
	input logic ycc_ready_o,
	input logic pair_valid_o
);

	int unsigned fail_count = 0;
	logic        accept;

	assign accept = ycc_valid_i && ycc_ready_o;

	// the byte stream cannot stall, so every offered word must be taken
	a_never_stalled: assert property (@(posedge vid_clk) disable iff (rst_i)
		ycc_valid_i |-> ycc_ready_o)
		else begin
			$error("word offered while the converter was busy");
			fail_count++;
		end

	a_pair_after_accept: assert property (@(posedge vid_clk) disable iff (rst_i)
		accept |-> ##5 pair_valid_o)
		else begin
			$error("no pixel pair 5 cycles after an accepted word");
			fail_count++;
		end

	a_no_stray_pair: assert property (@(posedge vid_clk) disable iff (rst_i)
		pair_valid_o |-> $past(accept, 5))
		else begin
			$error("pixel pair without an accepted word 5 cycles before");
			fail_count++;
		end

endmodule

bind bt656cap_colorspace bt656cap_properties i_properties (.*);

/* tests/tb_bt656cap.sv */
// ========================================================================
// Testbench for the BT.656 capture front end. Sends random lines of
// video, models the expected RGB565 pairs and hands them to the checker.
// ========================================================================

`include "bt656cap_settings.svh"

module tb_bt656cap import bt656cap_pkg::*; ();

	logic      vid_clk;
	logic      rst_i;
	sample_t   byte_i;
	logic      pix_ready_i;
	logic      pix_valid_o;
	pix_pair_t pix_o;
	logic      overflow_o;

	int   seed = 32'h54123fa1;
	int   cyc = 0;
	int   limit;
	int   y1_edge = 0;
	logic lat_arm = 1'b0;
	logic ready_rand = 1'b0;  // random back-pressure on the output

	bt656cap i_bt656cap (.*);

	bt656cap_checker i_checker (.vid_clk, .rst_i, .pix_valid_i(pix_valid_o), .pix_i(pix_o),
		.pix_ready_i, .overflow_i(overflow_o), .lat_arm_i(lat_arm), .cyc_i(cyc),
		.y1_edge_i(y1_edge));

	initial begin
		vid_clk = 1'b0;
		forever #4 vid_clk = ~vid_clk;
	end

	always @(posedge vid_clk) begin
		cyc <= cyc + 1;
		if (cyc >= limit) begin
			$display("run stopped after %0d cycles with %0d pairs still expected",
				cyc, i_checker.pending());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic int line_len(input int pairs);
		return 24 + 4 * pairs; // filler, SAV, active bytes, EAV
	endfunction

	function automatic int clip(input int v);
		return (v < 0) ? 0 : ((v > 255) ? 255 : v);
	endfunction

	// reference conversion, each product floored after the divide by 256
	function automatic rgb565_t ref_pixel(input int y, input int cb, input int cr);
		int r, g, b;
		r = clip(y + (((cr - 128) * int'(`BT656CAP_K_RCR)) >>> 8));
		g = clip(y - (((cb - 128) * int'(`BT656CAP_K_GCB)) >>> 8)
			- (((cr - 128) * int'(`BT656CAP_K_GCR)) >>> 8));
		b = clip(y + (((cb - 128) * int'(`BT656CAP_K_BCB)) >>> 8));
		return {r[7:3], g[7:2], b[7:3]};
	endfunction

	function automatic sample_t rnd_sample();
		int r;
		r = $random(seed);
		case (r[11:9])
			3'd0: return 8'h01;  // drives the channels towards clamping
			3'd1: return 8'hfe;
			default: return sample_t'(1 + (r[7:0] % 254));
		endcase
	endfunction

	task automatic send_byte(input sample_t b);
		int r;
		@(posedge vid_clk);
		byte_i <= b;
		if (ready_rand) begin
			r = $random(seed);
			pix_ready_i <= r[0];
		end
	endtask

	task automatic send_code(input logic f, input logic v, input logic h);
		send_byte(8'hff);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte({1'b1, f, v, h, 4'h0});
	endtask

	// keep is the number of leading pairs that are expected at the output
	task automatic send_line(input int pairs, input logic f, input logic v, input int keep);
		sample_t cb, y0, cr, y1;
		int      i;
		repeat (8) begin
			send_byte(8'h80);
			send_byte(8'h10);
		end
		send_code(f, v, 1'b0);
		for (i = 0; i < pairs; i++) begin
			cb = rnd_sample();
			y0 = rnd_sample();
			cr = rnd_sample();
			y1 = rnd_sample();
			send_byte(cb);
			send_byte(y0);
			send_byte(cr);
			send_byte(y1);
			if (i == 0)
				y1_edge = cyc + 1;
			if (!v && i < keep)
				i_checker.expect_pair('{px0: ref_pixel(y0, cb, cr),
					px1: ref_pixel(y1, cb, cr), field: f, sol: (i == 0)});
		end
		send_code(f, v, 1'b1);
	endtask

	task automatic drain();
		while (i_checker.pending() != 0)
			send_byte(8'h10);
		repeat (8) send_byte(8'h10); // any stray pair leaves the pipeline here
	endtask

	// ====================================================================
	// test sequence
	// ====================================================================
	initial begin
		rst_i       = 1'b1;
		byte_i      = 8'h10;
		pix_ready_i = 1'b1;
		limit = 2 + 7 * 8 + 9 * line_len(16) + 4 * line_len(10) + 6 * line_len(6)
			+ line_len(4) + line_len(12) + 200;
		repeat (2) @(posedge vid_clk);
		rst_i <= 1'b0;

		repeat (6) send_line(16, 1'b0, 1'b0, 16);
		drain();
		i_checker.end_test("conversion", 1'b0);

		repeat (2) send_line(10, 1'b1, 1'b0, 10);
		repeat (2) send_line(10, 1'b0, 1'b0, 10);
		drain();
		i_checker.end_test("field_and_sol", 1'b0);

		repeat (3) send_line(16, 1'b0, 1'b1, 0);
		drain();
		i_checker.end_test("vertical_blanking", 1'b0);

		ready_rand = 1'b1;
		repeat (6) send_line(6, 1'b0, 1'b0, 6);
		drain();
		ready_rand = 1'b0;
		pix_ready_i <= 1'b1;
		i_checker.end_test("back_pressure", 1'b0);

		lat_arm = 1'b1;
		send_line(4, 1'b0, 1'b0, 4);
		drain();
		lat_arm = 1'b0;
		i_checker.end_test("latency", 1'b0);

		pix_ready_i <= 1'b0;
		send_line(12, 1'b0, 1'b0, `BT656CAP_FIFO_DEPTH);
		repeat (8) send_byte(8'h10); // last pair is still in the converter
		pix_ready_i <= 1'b1;
		drain();
		i_checker.end_test("overflow", 1'b1);

		i_checker.report_totals(i_bt656cap.i_colorspace.i_properties.fail_count);
		if (i_checker.error_count == 0 && i_bt656cap.i_colorspace.i_properties.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
